/* hdl/fsync_pkg.sv */
package fsync_pkg;

  // one-dimensional node with an east-north and a west-south child
  localparam int unsigned N_RX_PORTS = 2;

  // request and response field sizes
  localparam int unsigned AGGR_WIDTH  = 8;
  localparam int unsigned ID_WIDTH    = 2;
  localparam int unsigned N_IDS       = 3;
  localparam int unsigned LEVEL_WIDTH = 3;

  // one table entry for every level and valid id
  localparam int unsigned N_ENTRIES   = 24;
  localparam int unsigned ENTRY_WIDTH = 5;

  localparam int unsigned FIFO_DEPTH = 2;

  typedef logic [AGGR_WIDTH-1:0]  aggr_t;
  typedef logic [ID_WIDTH-1:0]    id_t;
  typedef logic [LEVEL_WIDTH-1:0] level_t;

  // bit 0 marks the east-north side and bit 1 the west-south side
  typedef logic [1:0] side_t;

  localparam side_t SIDE_EN = 2'b01;
  localparam side_t SIDE_WS = 2'b10;

  // local FIFO payload holds level, id and error bit
  localparam int unsigned LOCAL_WIDTH = LEVEL_WIDTH + ID_WIDTH + 1;

  // remote FIFO payload holds the shifted aggregate and the id
  localparam int unsigned REMOTE_WIDTH = AGGR_WIDTH + ID_WIDTH;

  // what an RX port does with its request in the current cycle
  typedef enum logic [1:0] {
    ACT_IDLE,
    ACT_ROOT_CHECK,
    ACT_AGGR_SET,
    ACT_PASS_SET
  } rx_action_e;

endpackage

/* hdl/fsync_fifo.sv */
`timescale 1ns/10ps

module fsync_fifo #(
  parameter int unsigned DATA_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  push_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  pop_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  empty_o,
  output logic                  full_o,
  output logic                  err_o
);

  logic [DATA_WIDTH-1:0]                          mem_q[fsync_pkg::FIFO_DEPTH];
  logic [$clog2(fsync_pkg::FIFO_DEPTH)-1:0]       wr_ptr_q;
  logic [$clog2(fsync_pkg::FIFO_DEPTH)-1:0]       rd_ptr_q;
  logic [$clog2(fsync_pkg::FIFO_DEPTH+1)-1:0]     count_q;
  logic                                           do_push;
  logic                                           do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == fsync_pkg::FIFO_DEPTH);

  // a push into a full FIFO is dropped and a pop of an empty one is ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign err_o   = (push_i & full_o) | (pop_i & empty_o);

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == fsync_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == fsync_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* hdl/fsync_barrier_table.sv */
`timescale 1ns/10ps

module fsync_barrier_table (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              check_i[fsync_pkg::N_RX_PORTS],
  input  logic [fsync_pkg::ENTRY_WIDTH-1:0] index_i[fsync_pkg::N_RX_PORTS],
  output logic                              done_o[fsync_pkg::N_RX_PORTS],
  output logic                              dup_o[fsync_pkg::N_RX_PORTS]
);

  fsync_pkg::side_t mask_q[fsync_pkg::N_ENTRIES];
  fsync_pkg::side_t cur[fsync_pkg::N_RX_PORTS];
  logic             pair;

  for (genvar i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin : gen_read
    assign cur[i] = check_i[i] ? mask_q[index_i[i]] : '0;
  end

  // both children arriving together on an empty entry complete the barrier at once
  assign pair = check_i[0] & check_i[1] & (index_i[0] == index_i[1]) & (cur[0] == '0);

  for (genvar i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin : gen_result
    assign dup_o[i]  = check_i[i] & cur[i][i];
    // only port 0 reports the joint completion
    assign done_o[i] = check_i[i] & ~cur[i][i] & (cur[i][1-i] | (pair && i == 0));
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int e = 0; e < fsync_pkg::N_ENTRIES; e++) begin
        mask_q[e] <= '0;
      end
    end else begin
      for (int i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin
        if (done_o[i]) begin
          mask_q[index_i[i]] <= '0;
        end else if (check_i[i] && !dup_o[i] && !pair) begin
          mask_q[index_i[i]][i] <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/fsync_route_table.sv */
`timescale 1ns/10ps

module fsync_route_table (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              set_i[fsync_pkg::N_RX_PORTS],
  input  logic [fsync_pkg::ENTRY_WIDTH-1:0] index_i[fsync_pkg::N_RX_PORTS],
  output logic                              done_o[fsync_pkg::N_RX_PORTS],
  output logic                              dup_o[fsync_pkg::N_RX_PORTS],
  input  logic                              lk_valid_i,
  input  logic [fsync_pkg::ENTRY_WIDTH-1:0] lk_index_i,
  output fsync_pkg::side_t                  lk_side_o
);

  fsync_pkg::side_t mask_q[fsync_pkg::N_ENTRIES];
  fsync_pkg::side_t cur[fsync_pkg::N_RX_PORTS];
  logic             pair;
  logic             lk_hit_set;

  for (genvar i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin : gen_read
    assign cur[i] = set_i[i] ? mask_q[index_i[i]] : '0;
  end

  assign pair = set_i[0] & set_i[1] & (index_i[0] == index_i[1]) & (cur[0] == '0);

  // a set on an already complete entry finds its own bit and counts as dup
  for (genvar i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin : gen_result
    assign dup_o[i]  = set_i[i] & cur[i][i];
    assign done_o[i] = set_i[i] & ~cur[i][i] & (cur[i][1-i] | (pair && i == 0));
  end

  // the lookup sees the mask as it was before this cycle's sets
  assign lk_side_o = lk_valid_i ? mask_q[lk_index_i] : '0;

  always_comb begin
    lk_hit_set = 1'b0;
    for (int i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin
      if (set_i[i] && index_i[i] == lk_index_i) begin
        lk_hit_set = 1'b1;
      end
    end
  end

  // the entry keeps both sides after completion until the TX side looks it up
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int e = 0; e < fsync_pkg::N_ENTRIES; e++) begin
        mask_q[e] <= '0;
      end
    end else begin
      // a set on the looked-up entry keeps it from being cleared
      if (lk_valid_i && !lk_hit_set) begin
        mask_q[lk_index_i] <= '0;
      end
      for (int i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin
        if (set_i[i]) begin
          mask_q[index_i[i]][i] <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/fsync_ctrl.sv */
`timescale 1ns/10ps

module fsync_ctrl (
  input  fsync_pkg::aggr_t             req_aggr_i[fsync_pkg::N_RX_PORTS],
  input  fsync_pkg::id_t               req_id_i[fsync_pkg::N_RX_PORTS],
  input  logic                         check_rf_i[fsync_pkg::N_RX_PORTS],
  input  logic                         local_i[fsync_pkg::N_RX_PORTS],
  input  logic                         root_i[fsync_pkg::N_RX_PORTS],

  input  fsync_pkg::level_t            rsp_level_i,
  input  fsync_pkg::id_t               rsp_id_i,
  input  logic                         rsp_aggr0_i,
  input  logic                         check_br_i,
  input  logic                         check_aggr_i,

  input  logic                         bar_done_i[fsync_pkg::N_RX_PORTS],
  input  logic                         bar_dup_i[fsync_pkg::N_RX_PORTS],
  input  logic                         rt_done_i[fsync_pkg::N_RX_PORTS],
  input  logic                         rt_dup_i[fsync_pkg::N_RX_PORTS],
  input  fsync_pkg::side_t             lk_side_i,

  output logic                         bar_check_o[fsync_pkg::N_RX_PORTS],
  output logic [fsync_pkg::ENTRY_WIDTH-1:0] bar_index_o[fsync_pkg::N_RX_PORTS],
  output logic                         rt_set_o[fsync_pkg::N_RX_PORTS],
  output logic [fsync_pkg::ENTRY_WIDTH-1:0] rt_index_o[fsync_pkg::N_RX_PORTS],
  output logic                         lk_valid_o,
  output logic [fsync_pkg::ENTRY_WIDTH-1:0] lk_index_o,

  output logic                         push_local_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::level_t            local_level_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::id_t               local_id_o[fsync_pkg::N_RX_PORTS],
  output logic                         local_error_o[fsync_pkg::N_RX_PORTS],
  output logic                         push_remote_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::aggr_t             remote_aggr_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::id_t               remote_id_o[fsync_pkg::N_RX_PORTS],

  output logic                         en_br_o,
  output logic                         ws_br_o
);

  // entries are laid out level by level with the valid ids side by side
  function automatic logic [fsync_pkg::ENTRY_WIDTH-1:0] entry_index(
    input fsync_pkg::level_t lvl,
    input fsync_pkg::id_t    id
  );
    return fsync_pkg::ENTRY_WIDTH'(lvl * fsync_pkg::N_IDS + id);
  endfunction

  fsync_pkg::level_t      level[fsync_pkg::N_RX_PORTS];
  logic                   bad[fsync_pkg::N_RX_PORTS];
  fsync_pkg::rx_action_e  action[fsync_pkg::N_RX_PORTS];
  logic                   tx_id_ok;
  fsync_pkg::side_t       route;

  for (genvar i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin : gen_rx
    // the level is the position of the highest set aggregate bit
    always_comb begin
      level[i] = '0;
      for (int j = 0; j < fsync_pkg::AGGR_WIDTH; j++) begin
        if (req_aggr_i[i][j]) begin
          level[i] = fsync_pkg::level_t'(j);
        end
      end
    end

    assign bad[i] = (req_aggr_i[i] == '0) || (req_id_i[i] >= fsync_pkg::N_IDS);

    always_comb begin
      if (!check_rf_i[i]) begin
        action[i] = fsync_pkg::ACT_IDLE;
      end else if (!local_i[i]) begin
        action[i] = fsync_pkg::ACT_PASS_SET;
      end else if (root_i[i]) begin
        action[i] = fsync_pkg::ACT_ROOT_CHECK;
      end else begin
        action[i] = fsync_pkg::ACT_AGGR_SET;
      end
    end

    // a bad request keeps away from the tables and only answers with an error
    always_comb begin
      bar_check_o[i]   = 1'b0;
      rt_set_o[i]      = 1'b0;
      push_local_o[i]  = 1'b0;
      local_error_o[i] = 1'b0;
      push_remote_o[i] = 1'b0;
      case (action[i])
        fsync_pkg::ACT_ROOT_CHECK: begin
          bar_check_o[i]   = ~bad[i];
          push_local_o[i]  = bad[i] | bar_done_i[i] | bar_dup_i[i];
          local_error_o[i] = bad[i] | bar_dup_i[i];
        end
        fsync_pkg::ACT_AGGR_SET: begin
          rt_set_o[i]      = ~bad[i];
          push_remote_o[i] = ~bad[i] & rt_done_i[i];
          push_local_o[i]  = bad[i] | rt_dup_i[i];
          local_error_o[i] = bad[i] | rt_dup_i[i];
        end
        fsync_pkg::ACT_PASS_SET: begin
          rt_set_o[i] = ~bad[i];
        end
        default: begin
        end
      endcase
    end

    assign bar_index_o[i]   = entry_index(level[i], req_id_i[i]);
    assign rt_index_o[i]    = entry_index(level[i], req_id_i[i]);
    assign local_level_o[i] = level[i];
    assign local_id_o[i]    = req_id_i[i];

    // the parent sees the request one level down
    assign remote_aggr_o[i] = req_aggr_i[i] >> 1;
    assign remote_id_o[i]   = req_id_i[i];
  end

  assign tx_id_ok   = (rsp_id_i < fsync_pkg::N_IDS);
  assign lk_index_o = entry_index(rsp_level_i, rsp_id_i);
  assign lk_valid_o = check_br_i & ~check_aggr_i & tx_id_ok;

  // the aggregate pattern takes priority over the stored arrival sides
  always_comb begin
    route = '0;
    if (check_aggr_i) begin
      route = rsp_aggr0_i ? fsync_pkg::SIDE_WS : fsync_pkg::SIDE_EN;
    end else if (check_br_i && tx_id_ok) begin
      route = lk_side_i;
    end
  end

  assign {ws_br_o, en_br_o} = route;

endmodule

/* hdl/fsync_cc.sv */
`timescale 1ns/10ps

module fsync_cc (
  input  logic              clk_i,
  input  logic              rst_i,

  input  fsync_pkg::aggr_t  req_aggr_i[fsync_pkg::N_RX_PORTS],
  input  fsync_pkg::id_t    req_id_i[fsync_pkg::N_RX_PORTS],
  input  logic              check_rf_i[fsync_pkg::N_RX_PORTS],
  input  logic              local_i[fsync_pkg::N_RX_PORTS],
  input  logic              root_i[fsync_pkg::N_RX_PORTS],

  input  fsync_pkg::level_t rsp_level_i,
  input  fsync_pkg::id_t    rsp_id_i,
  input  fsync_pkg::aggr_t  rsp_aggr_i,
  input  logic              check_br_i,
  input  logic              check_aggr_i,
  output logic              en_br_o,
  output logic              ws_br_o,

  output logic              local_empty_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::level_t local_level_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::id_t    local_id_o[fsync_pkg::N_RX_PORTS],
  output logic              local_error_o[fsync_pkg::N_RX_PORTS],
  input  logic              local_pop_i[fsync_pkg::N_RX_PORTS],

  output logic              remote_empty_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::aggr_t  remote_aggr_o[fsync_pkg::N_RX_PORTS],
  output fsync_pkg::id_t    remote_id_o[fsync_pkg::N_RX_PORTS],
  input  logic              remote_pop_i[fsync_pkg::N_RX_PORTS],

  output logic              detected_error_o[fsync_pkg::N_RX_PORTS]
);

  logic                              bar_check[fsync_pkg::N_RX_PORTS];
  logic [fsync_pkg::ENTRY_WIDTH-1:0] bar_index[fsync_pkg::N_RX_PORTS];
  logic                              bar_done[fsync_pkg::N_RX_PORTS];
  logic                              bar_dup[fsync_pkg::N_RX_PORTS];
  logic                              rt_set[fsync_pkg::N_RX_PORTS];
  logic [fsync_pkg::ENTRY_WIDTH-1:0] rt_index[fsync_pkg::N_RX_PORTS];
  logic                              rt_done[fsync_pkg::N_RX_PORTS];
  logic                              rt_dup[fsync_pkg::N_RX_PORTS];
  logic                              lk_valid;
  logic [fsync_pkg::ENTRY_WIDTH-1:0] lk_index;
  fsync_pkg::side_t                  lk_side;

  logic                              push_local[fsync_pkg::N_RX_PORTS];
  fsync_pkg::level_t                 push_level[fsync_pkg::N_RX_PORTS];
  fsync_pkg::id_t                    push_id[fsync_pkg::N_RX_PORTS];
  logic                              push_error[fsync_pkg::N_RX_PORTS];
  logic                              push_remote[fsync_pkg::N_RX_PORTS];
  fsync_pkg::aggr_t                  up_aggr[fsync_pkg::N_RX_PORTS];
  fsync_pkg::id_t                    up_id[fsync_pkg::N_RX_PORTS];

  fsync_ctrl i_ctrl (
    .req_aggr_i    ( req_aggr_i    ),
    .req_id_i      ( req_id_i      ),
    .check_rf_i    ( check_rf_i    ),
    .local_i       ( local_i       ),
    .root_i        ( root_i        ),
    .rsp_level_i   ( rsp_level_i   ),
    .rsp_id_i      ( rsp_id_i      ),
    .rsp_aggr0_i   ( rsp_aggr_i[0] ),
    .check_br_i    ( check_br_i    ),
    .check_aggr_i  ( check_aggr_i  ),
    .bar_done_i    ( bar_done      ),
    .bar_dup_i     ( bar_dup       ),
    .rt_done_i     ( rt_done       ),
    .rt_dup_i      ( rt_dup        ),
    .lk_side_i     ( lk_side       ),
    .bar_check_o   ( bar_check     ),
    .bar_index_o   ( bar_index     ),
    .rt_set_o      ( rt_set        ),
    .rt_index_o    ( rt_index      ),
    .lk_valid_o    ( lk_valid      ),
    .lk_index_o    ( lk_index      ),
    .push_local_o  ( push_local    ),
    .local_level_o ( push_level    ),
    .local_id_o    ( push_id       ),
    .local_error_o ( push_error    ),
    .push_remote_o ( push_remote   ),
    .remote_aggr_o ( up_aggr       ),
    .remote_id_o   ( up_id         ),
    .en_br_o       ( en_br_o       ),
    .ws_br_o       ( ws_br_o       )
  );

  fsync_barrier_table i_barrier_table (
    .clk_i   ( clk_i     ),
    .rst_i   ( rst_i     ),
    .check_i ( bar_check ),
    .index_i ( bar_index ),
    .done_o  ( bar_done  ),
    .dup_o   ( bar_dup   )
  );

  fsync_route_table i_route_table (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .set_i      ( rt_set   ),
    .index_i    ( rt_index ),
    .done_o     ( rt_done  ),
    .dup_o      ( rt_dup   ),
    .lk_valid_i ( lk_valid ),
    .lk_index_i ( lk_index ),
    .lk_side_o  ( lk_side  )
  );

  for (genvar i = 0; i < fsync_pkg::N_RX_PORTS; i++) begin : gen_fifos
    logic [fsync_pkg::LOCAL_WIDTH-1:0]  local_data;
    logic [fsync_pkg::REMOTE_WIDTH-1:0] remote_data;
    logic                               local_err;
    logic                               remote_err;

    // wake responses for the children of this port
    fsync_fifo #(
      .DATA_WIDTH ( fsync_pkg::LOCAL_WIDTH )
    ) i_local_fifo (
      .clk_i   ( clk_i                                      ),
      .rst_i   ( rst_i                                      ),
      .push_i  ( push_local[i]                              ),
      .data_i  ( {push_level[i], push_id[i], push_error[i]} ),
      .pop_i   ( local_pop_i[i]                             ),
      .data_o  ( local_data                                 ),
      .empty_o ( local_empty_o[i]                           ),
      .full_o  (                                            ),
      .err_o   ( local_err                                  )
    );

    // requests travelling up to the parent node
    fsync_fifo #(
      .DATA_WIDTH ( fsync_pkg::REMOTE_WIDTH )
    ) i_remote_fifo (
      .clk_i   ( clk_i                 ),
      .rst_i   ( rst_i                 ),
      .push_i  ( push_remote[i]        ),
      .data_i  ( {up_aggr[i], up_id[i]} ),
      .pop_i   ( remote_pop_i[i]       ),
      .data_o  ( remote_data           ),
      .empty_o ( remote_empty_o[i]     ),
      .full_o  (                       ),
      .err_o   ( remote_err            )
    );

    assign {local_level_o[i], local_id_o[i], local_error_o[i]} = local_data;
    assign {remote_aggr_o[i], remote_id_o[i]}                  = remote_data;

    assign detected_error_o[i] = local_err | remote_err;
  end

endmodule

/* bench/fsync_model.svh */
`ifndef FSYNC_MODEL_SVH
`define FSYNC_MODEL_SVH

// table slots are keyed by {level, id}, so 32 slots cover every legal pair
fsync_pkg::side_t bar_m[32];
fsync_pkg::side_t bar_n[32];
fsync_pkg::side_t rt_m[32];
fsync_pkg::side_t rt_n[32];

// FIFO contents with the head in slot 0
logic [fsync_pkg::LOCAL_WIDTH-1:0]  lq_m[2][fsync_pkg::FIFO_DEPTH];
logic [fsync_pkg::REMOTE_WIDTH-1:0] rq_m[2][fsync_pkg::FIFO_DEPTH];
int                                 lcnt_m[2];
int                                 rcnt_m[2];

// what the DUT is expected to do in the cycle in progress
logic                               lpush_e[2];
logic [fsync_pkg::LOCAL_WIDTH-1:0]  ldata_e[2];
logic                               rpush_e[2];
logic [fsync_pkg::REMOTE_WIDTH-1:0] rdata_e[2];
logic                               err_e[2];
fsync_pkg::side_t                   route_e;

task automatic reset_model();
  for (int s = 0; s < 32; s++) begin
    bar_m[s] = '0;
    rt_m[s]  = '0;
  end
  for (int p = 0; p < 2; p++) begin
    lcnt_m[p] = 0;
    rcnt_m[p] = 0;
  end
endtask

function automatic int top_bit(input fsync_pkg::aggr_t aggr);
  int pos;
  pos = 0;
  for (int b = 0; b < fsync_pkg::AGGR_WIDTH; b++) begin
    if (aggr[b]) begin
      pos = b;
    end
  end
  return pos;
endfunction

// an arrival completes when the other side is waiting, or when both come together on a
// clear slot, where port 0 takes the completion
task automatic find_arrivals(
  input  logic             use_it[2],
  input  int               idx[2],
  input  fsync_pkg::side_t tab[32],
  output logic             done[2],
  output logic             dup[2]
);
  logic             pair;
  fsync_pkg::side_t cur;
  pair = use_it[0] && use_it[1] && (idx[0] == idx[1]) && (tab[idx[0]] == '0);
  for (int p = 0; p < 2; p++) begin
    cur     = tab[idx[p]];
    dup[p]  = use_it[p] && cur[p];
    done[p] = use_it[p] && !cur[p] && (cur[1-p] || (pair && p == 0));
  end
endtask

task automatic predict_outputs();
  int   idx[2];
  int   lvl[2];
  logic bad[2];
  logic at_root[2];
  logic at_aggr[2];
  logic bar_use[2];
  logic rt_use[2];
  logic bar_done[2];
  logic bar_dup[2];
  logic rt_done[2];
  logic rt_dup[2];
  int   tx_slot;
  logic tx_hit;
  bar_n = bar_m;
  rt_n  = rt_m;
  for (int p = 0; p < 2; p++) begin
    lvl[p]     = top_bit(req_aggr[p]);
    idx[p]     = lvl[p] * 4 + req_id[p];
    bad[p]     = (req_aggr[p] == '0) || (req_id[p] == 2'd3);
    at_root[p] = check_rf[p] && local_sel[p] && root_sel[p];
    at_aggr[p] = check_rf[p] && local_sel[p] && !root_sel[p];
    bar_use[p] = at_root[p] && !bad[p];
    rt_use[p]  = (at_aggr[p] || (check_rf[p] && !local_sel[p])) && !bad[p];
  end
  find_arrivals(bar_use, idx, bar_m, bar_done, bar_dup);
  find_arrivals(rt_use, idx, rt_m, rt_done, rt_dup);

  for (int p = 0; p < 2; p++) begin
    lpush_e[p] = (at_root[p] && (bad[p] || bar_done[p] || bar_dup[p])) ||
                 (at_aggr[p] && (bad[p] || rt_dup[p]));
    // only a completed root barrier answers without the error bit
    ldata_e[p] = {fsync_pkg::level_t'(lvl[p]), req_id[p], !bar_done[p]};
    rpush_e[p] = at_aggr[p] && rt_done[p];
    rdata_e[p] = {req_aggr[p] >> 1, req_id[p]};
    if (bar_use[p] && !bar_dup[p]) begin
      bar_n[idx[p]][p] = 1'b1;
    end
  end
  for (int p = 0; p < 2; p++) begin
    if (bar_done[p]) begin
      bar_n[idx[p]] = '0;
    end
  end

  route_e = '0;
  tx_slot = rsp_level * 4 + rsp_id;
  if (check_aggr) begin
    route_e = rsp_aggr[0] ? fsync_pkg::SIDE_WS : fsync_pkg::SIDE_EN;
  end else if (check_br && rsp_id != 2'd3) begin
    route_e = rt_m[tx_slot];
    tx_hit  = (rt_use[0] && idx[0] == tx_slot) || (rt_use[1] && idx[1] == tx_slot);
    if (!tx_hit) begin
      rt_n[tx_slot] = '0;
    end
  end
  for (int p = 0; p < 2; p++) begin
    if (rt_use[p]) begin
      rt_n[idx[p]][p] = 1'b1;
    end
    err_e[p] = (lpush_e[p] && lcnt_m[p] == fsync_pkg::FIFO_DEPTH) ||
               (local_pop[p] && lcnt_m[p] == 0) ||
               (rpush_e[p] && rcnt_m[p] == fsync_pkg::FIFO_DEPTH) ||
               (remote_pop[p] && rcnt_m[p] == 0);
  end
endtask

task automatic advance_model();
  logic l_full;
  logic r_full;
  bar_m = bar_n;
  rt_m  = rt_n;
  for (int p = 0; p < 2; p++) begin
    l_full = (lcnt_m[p] == fsync_pkg::FIFO_DEPTH);
    r_full = (rcnt_m[p] == fsync_pkg::FIFO_DEPTH);
    if (local_pop[p] && lcnt_m[p] > 0) begin
      for (int k = 1; k < fsync_pkg::FIFO_DEPTH; k++) begin
        lq_m[p][k-1] = lq_m[p][k];
      end
      lcnt_m[p]--;
    end
    if (remote_pop[p] && rcnt_m[p] > 0) begin
      for (int k = 1; k < fsync_pkg::FIFO_DEPTH; k++) begin
        rq_m[p][k-1] = rq_m[p][k];
      end
      rcnt_m[p]--;
    end
    // a push into a full FIFO is lost even when a pop frees a slot
    if (lpush_e[p] && !l_full) begin
      lq_m[p][lcnt_m[p]] = ldata_e[p];
      lcnt_m[p]++;
    end
    if (rpush_e[p] && !r_full) begin
      rq_m[p][rcnt_m[p]] = rdata_e[p];
      rcnt_m[p]++;
    end
  end
endtask

`endif

/* bench/fsync_cc_tb.sv */
`timescale 1ns/10ps

module fsync_cc_tb;

  localparam int DIRECTED_CYCLES = 28;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int CYCLE_LIMIT     = 2 * (DIRECTED_CYCLES + RANDOM_CYCLES) + 100;

  logic              clk;
  logic              rst;
  fsync_pkg::aggr_t  req_aggr[2];
  fsync_pkg::id_t    req_id[2];
  logic              check_rf[2];
  logic              local_sel[2];
  logic              root_sel[2];
  fsync_pkg::level_t rsp_level;
  fsync_pkg::id_t    rsp_id;
  fsync_pkg::aggr_t  rsp_aggr;
  logic              check_br;
  logic              check_aggr;
  logic              en_br;
  logic              ws_br;
  logic              local_empty[2];
  fsync_pkg::level_t local_level[2];
  fsync_pkg::id_t    local_id[2];
  logic              local_error[2];
  logic              local_pop[2];
  logic              remote_empty[2];
  fsync_pkg::aggr_t  remote_aggr[2];
  fsync_pkg::id_t    remote_id[2];
  logic              remote_pop[2];
  logic              detected_error[2];

  logic [31:0] lfsr_q = 32'hcbf7c909;
  int          checks = 0;
  int          errors = 0;
  int          cycle_count = 0;

  `include "fsync_model.svh"

  fsync_cc dut_i (
    .clk_i            ( clk            ),
    .rst_i            ( rst            ),
    .req_aggr_i       ( req_aggr       ),
    .req_id_i         ( req_id         ),
    .check_rf_i       ( check_rf       ),
    .local_i          ( local_sel      ),
    .root_i           ( root_sel       ),
    .rsp_level_i      ( rsp_level      ),
    .rsp_id_i         ( rsp_id         ),
    .rsp_aggr_i       ( rsp_aggr       ),
    .check_br_i       ( check_br       ),
    .check_aggr_i     ( check_aggr     ),
    .en_br_o          ( en_br          ),
    .ws_br_o          ( ws_br          ),
    .local_empty_o    ( local_empty    ),
    .local_level_o    ( local_level    ),
    .local_id_o       ( local_id       ),
    .local_error_o    ( local_error    ),
    .local_pop_i      ( local_pop      ),
    .remote_empty_o   ( remote_empty   ),
    .remote_aggr_o    ( remote_aggr    ),
    .remote_id_o      ( remote_id      ),
    .remote_pop_i     ( remote_pop     ),
    .detected_error_o ( detected_error )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // the taps are 32, 22, 2 and 1 and the register steps once for every bit handed out
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %s: expected 0x%0h, got 0x%0h", name, want, got);
    end
  endtask

  task automatic drive_idle();
    for (int p = 0; p < 2; p++) begin
      req_aggr[p]   = '0;
      req_id[p]     = '0;
      check_rf[p]   = 1'b0;
      local_sel[p]  = 1'b0;
      root_sel[p]   = 1'b0;
      local_pop[p]  = 1'b0;
      remote_pop[p] = 1'b0;
    end
    rsp_level  = '0;
    rsp_id     = '0;
    rsp_aggr   = '0;
    check_br   = 1'b0;
    check_aggr = 1'b0;
  endtask

  task automatic send_request(input int port, input fsync_pkg::aggr_t aggr,
                              input fsync_pkg::id_t id, input logic is_local,
                              input logic is_root);
    req_aggr[port]  = aggr;
    req_id[port]    = id;
    check_rf[port]  = 1'b1;
    local_sel[port] = is_local;
    root_sel[port]  = is_root;
  endtask

  task automatic query_route(input fsync_pkg::level_t level, input fsync_pkg::id_t id,
                             input fsync_pkg::aggr_t aggr, input logic by_table,
                             input logic by_aggr);
    rsp_level  = level;
    rsp_id     = id;
    rsp_aggr   = aggr;
    check_br   = by_table;
    check_aggr = by_aggr;
  endtask

  task automatic random_inputs();
    for (int p = 0; p < 2; p++) begin
      check_rf[p]   = 1'(lfsr_take(1));
      local_sel[p]  = |lfsr_take(2);
      root_sel[p]   = 1'(lfsr_take(1));
      // small aggregates keep the traffic on a few slots and zero shows up now and then
      req_aggr[p]   = fsync_pkg::aggr_t'(lfsr_take(4));
      req_id[p]     = fsync_pkg::id_t'(lfsr_take(2));
      local_pop[p]  = (lfsr_take(2) == 32'd3);
      remote_pop[p] = (lfsr_take(2) == 32'd3);
    end
    rsp_level  = fsync_pkg::level_t'(lfsr_take(2));
    rsp_id     = fsync_pkg::id_t'(lfsr_take(2));
    rsp_aggr   = fsync_pkg::aggr_t'(lfsr_take(8));
    check_br   = 1'(lfsr_take(1));
    check_aggr = (lfsr_take(2) == 32'd3);
  endtask

  task automatic check_outputs();
    check_value("en_br_o", en_br, route_e[0]);
    check_value("ws_br_o", ws_br, route_e[1]);
    for (int p = 0; p < 2; p++) begin
      check_value($sformatf("detected_error_o[%0d]", p), detected_error[p], err_e[p]);
      check_value($sformatf("local_empty_o[%0d]", p), local_empty[p], lcnt_m[p] == 0);
      if (lcnt_m[p] > 0) begin
        check_value($sformatf("local_level_o[%0d]", p), local_level[p], lq_m[p][0][5:3]);
        check_value($sformatf("local_id_o[%0d]", p), local_id[p], lq_m[p][0][2:1]);
        check_value($sformatf("local_error_o[%0d]", p), local_error[p], lq_m[p][0][0]);
      end
      check_value($sformatf("remote_empty_o[%0d]", p), remote_empty[p], rcnt_m[p] == 0);
      if (rcnt_m[p] > 0) begin
        check_value($sformatf("remote_aggr_o[%0d]", p), remote_aggr[p], rq_m[p][0][9:2]);
        check_value($sformatf("remote_id_o[%0d]", p), remote_id[p], rq_m[p][0][1:0]);
      end
    end
  endtask

  // inputs are in place 2 ns after the edge, outputs are compared at the falling edge
  task automatic step_cycle();
    predict_outputs();
    @(negedge clk);
    check_outputs();
    advance_model();
    @(posedge clk);
    #2;
    drive_idle();
  endtask

  initial begin
    rst = 1'b1;
    drive_idle();
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_model();
    step_cycle();

    // root barrier with port 1 first, then a same-cycle pair
    send_request(1, 8'h04, 2'd1, 1'b1, 1'b1);
    step_cycle();
    send_request(0, 8'h04, 2'd1, 1'b1, 1'b1);
    step_cycle();
    check_value("local_empty_o[0]", local_empty[0], 0);
    check_value("local_level_o[0]", local_level[0], 2);
    check_value("local_id_o[0]", local_id[0], 1);
    check_value("local_error_o[0]", local_error[0], 0);
    local_pop[0] = 1'b1;
    step_cycle();
    send_request(0, 8'h10, 2'd2, 1'b1, 1'b1);
    send_request(1, 8'h10, 2'd2, 1'b1, 1'b1);
    step_cycle();
    check_value("local_empty_o[0]", local_empty[0], 0);
    check_value("local_empty_o[1]", local_empty[1], 1);
    check_value("local_level_o[0]", local_level[0], 4);
    local_pop[0] = 1'b1;
    step_cycle();

    // aggregate completion goes up one level and leaves both sides for back-routing
    send_request(0, 8'h06, 2'd0, 1'b1, 1'b0);
    step_cycle();
    send_request(1, 8'h06, 2'd0, 1'b1, 1'b0);
    step_cycle();
    check_value("remote_empty_o[1]", remote_empty[1], 0);
    check_value("remote_aggr_o[1]", remote_aggr[1], 8'h03);
    check_value("remote_id_o[1]", remote_id[1], 0);
    check_value("remote_empty_o[0]", remote_empty[0], 1);
    query_route(3'd2, 2'd0, 8'h00, 1'b1, 1'b0);
    remote_pop[1] = 1'b1;
    step_cycle();
    query_route(3'd2, 2'd0, 8'h00, 1'b1, 1'b0);
    step_cycle();

    // pass-through records the side only
    send_request(1, 8'h20, 2'd2, 1'b0, 1'b0);
    step_cycle();
    for (int p = 0; p < 2; p++) begin
      check_value($sformatf("local_empty_o[%0d]", p), local_empty[p], 1);
      check_value($sformatf("remote_empty_o[%0d]", p), remote_empty[p], 1);
    end
    query_route(3'd5, 2'd2, 8'h00, 1'b1, 1'b0);
    step_cycle();
    send_request(0, 8'h20, 2'd2, 1'b0, 1'b0);
    step_cycle();
    query_route(3'd5, 2'd2, 8'h01, 1'b1, 1'b1);
    step_cycle();
    query_route(3'd5, 2'd2, 8'h00, 1'b1, 1'b0);
    step_cycle();
    query_route(3'd0, 2'd0, 8'h02, 1'b0, 1'b1);
    step_cycle();

    // bad requests and a repeated arrival answer with an error
    send_request(0, 8'h00, 2'd1, 1'b1, 1'b1);
    send_request(1, 8'h08, 2'd3, 1'b1, 1'b0);
    step_cycle();
    check_value("local_error_o[0]", local_error[0], 1);
    check_value("local_level_o[1]", local_level[1], 3);
    check_value("local_id_o[1]", local_id[1], 3);
    check_value("local_error_o[1]", local_error[1], 1);
    local_pop[0] = 1'b1;
    local_pop[1] = 1'b1;
    // level 4 with id 0 sits right after the illegal id 3 of level 3 and stays empty
    query_route(3'd4, 2'd0, 8'h00, 1'b1, 1'b0);
    step_cycle();
    send_request(0, 8'h01, 2'd2, 1'b1, 1'b0);
    step_cycle();
    send_request(0, 8'h01, 2'd2, 1'b1, 1'b0);
    step_cycle();
    check_value("local_error_o[0]", local_error[0], 1);
    local_pop[0] = 1'b1;
    step_cycle();

    // misuse of the FIFOs
    local_pop[1] = 1'b1;
    step_cycle();
    repeat (3) begin
      send_request(0, 8'h00, 2'd0, 1'b1, 1'b1);
      step_cycle();
    end
    repeat (2) begin
      local_pop[0] = 1'b1;
      step_cycle();
    end
    remote_pop[0] = 1'b1;
    step_cycle();

    repeat (RANDOM_CYCLES) begin
      random_inputs();
      step_cycle();
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
hdl/fsync_pkg.sv
hdl/fsync_fifo.sv
hdl/fsync_barrier_table.sv
hdl/fsync_route_table.sv
hdl/fsync_ctrl.sv
hdl/fsync_cc.sv
bench/fsync_cc_tb.sv

/* Bender.yml */
package:
  name: fsync_cc

sources:
  - hdl/fsync_pkg.sv
  - hdl/fsync_fifo.sv
  - hdl/fsync_barrier_table.sv
  - hdl/fsync_route_table.sv
  - hdl/fsync_ctrl.sv
  - hdl/fsync_cc.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/fsync_cc_tb.sv
